/* logic/cache_pkg.sv */
package cache_pkg;

    // CPU side of the caches
    typedef logic [31:0] addr_t;    // Byte address
    typedef logic [31:0] word_t;
    typedef logic [3:0]  strb_t;    // All zero means derive from size and offset

    // Fourth code behaves as a word
    typedef enum logic [1:0] {
        size_byte = 2'b00,
        size_half = 2'b01,
        size_word = 2'b10
    } size_t;

endpackage

/* logic/mem_pkg.sv */
package mem_pkg;

    // Requester index at the arbiter
    typedef logic [0:0] req_id_t;

    typedef enum logic [1:0] {
        arb_idle       = 2'b00,
        arb_wait_data  = 2'b01,    // Read owner waits for its line
        arb_done_write = 2'b10
    } arb_state_t;

endpackage

/* logic/data_cache.sv */
`timescale 1ns/1ps

module data_cache import cache_pkg::*; #(
    parameter int LINE_BYTES = 16,
    parameter int N_LINES    = 4
) (
    input  logic                    clk,
    input  logic                    rstn,

    input  logic                    cpu_req,
    input  logic                    cpu_wr,        // 1 = store
    input  addr_t                   cpu_addr,
    input  word_t                   cpu_wdata,
    input  strb_t                   cpu_wstrb,
    input  size_t                   cpu_size,
    output logic                    cpu_ready,
    output word_t                   cpu_rdata,
    output logic                    cpu_rvalid,
    output logic                    cpu_hit,

    output logic                    mem_req,
    output logic                    mem_we,
    output addr_t                   mem_addr,      // Line aligned
    output logic [LINE_BYTES*8-1:0] mem_wdata,
    input  logic                    mem_gnt,
    input  logic                    mem_rvalid,
    input  logic [LINE_BYTES*8-1:0] mem_rdata
);

    localparam int OFF_BITS = $clog2(LINE_BYTES);
    localparam int IDX_BITS = $clog2(N_LINES);
    localparam int TAG_BITS = 32 - OFF_BITS - IDX_BITS;
    localparam int LINE_W   = LINE_BYTES * 8;

    typedef enum logic [1:0] {
        st_idle      = 2'b00,
        st_writeback = 2'b01,
        st_refill    = 2'b10
    } state_t;

    state_t              state;

    logic [TAG_BITS-1:0] tag_arr   [N_LINES];
    logic [LINE_W-1:0]   data_arr  [N_LINES];
    logic                valid_arr [N_LINES];
    logic                dirty_arr [N_LINES];

    // Miss in progress
    logic                pend_wr;
    addr_t               pend_addr;
    word_t               pend_wdata;
    strb_t               pend_strb;
    size_t               pend_size;

    logic [IDX_BITS-1:0] cur_idx;
    logic [TAG_BITS-1:0] cur_tag;
    logic [IDX_BITS-1:0] pend_idx;
    logic [TAG_BITS-1:0] pend_tag;
    strb_t               cur_strb;
    logic                accept;
    logic                victim_dirty;
    logic                fill;

    function automatic strb_t size_strb(input logic [1:0] off, input size_t size);
        case (size)
            size_byte: return strb_t'(4'b0001 << off);
            size_half: return off[1] ? 4'b1100 : 4'b0011;
            default:   return 4'b1111;
        endcase
    endfunction

    function automatic word_t extract(input logic [LINE_W-1:0] line, input addr_t addr,
                                      input size_t size);
        int    woff;
        word_t word;
        woff = int'(addr[OFF_BITS-1:0]) >> 2;
        word = line[woff*32 +: 32];
        case (size)
            size_byte: return {24'h0, word[addr[1:0]*8 +: 8]};
            size_half: return {16'h0, word[addr[1]*16 +: 16]};
            default:   return word;
        endcase
    endfunction

    function automatic logic [LINE_W-1:0] merge(input logic [LINE_W-1:0] line,
                                                input addr_t addr, input word_t wdata,
                                                input strb_t strb);
        int                woff;
        logic [LINE_W-1:0] res;
        woff = int'(addr[OFF_BITS-1:0]) >> 2;
        res  = line;
        for (int b = 0; b < 4; b++) begin
            if (strb[b])
                res[woff*32 + b*8 +: 8] = wdata[b*8 +: 8];
        end
        return res;
    endfunction

    assign cur_idx  = cpu_addr[OFF_BITS +: IDX_BITS];
    assign cur_tag  = cpu_addr[31 -: TAG_BITS];
    assign pend_idx = pend_addr[OFF_BITS +: IDX_BITS];
    assign pend_tag = pend_addr[31 -: TAG_BITS];

    assign cpu_hit      = valid_arr[cur_idx] && (tag_arr[cur_idx] == cur_tag);
    assign victim_dirty = valid_arr[cur_idx] && dirty_arr[cur_idx];
    assign cur_strb     = (cpu_wstrb != '0) ? cpu_wstrb : size_strb(cpu_addr[1:0], cpu_size);
    assign accept       = cpu_req && cpu_ready && (state == st_idle);
    assign fill         = (state == st_refill) && mem_rvalid;

    // Arrays, pending request and outgoing line
    always_ff @(posedge clk) begin
        if (accept && cpu_hit) begin
            if (cpu_wr)
                data_arr[cur_idx] <= merge(data_arr[cur_idx], cpu_addr, cpu_wdata, cur_strb);
            else
                cpu_rdata <= extract(data_arr[cur_idx], cpu_addr, cpu_size);
        end
        if (accept && !cpu_hit) begin
            pend_wr    <= cpu_wr;
            pend_addr  <= cpu_addr;
            pend_wdata <= cpu_wdata;
            pend_strb  <= cur_strb;
            pend_size  <= cpu_size;
            mem_wdata  <= data_arr[cur_idx];
            if (victim_dirty)
                mem_addr <= {tag_arr[cur_idx], cur_idx, {OFF_BITS{1'b0}}};
            else
                mem_addr <= {cpu_addr[31:OFF_BITS], {OFF_BITS{1'b0}}};
        end
        if (state == st_writeback && mem_gnt)
            mem_addr <= {pend_addr[31:OFF_BITS], {OFF_BITS{1'b0}}};   // Switch to refill
        if (fill) begin
            tag_arr[pend_idx] <= pend_tag;
            if (pend_wr) begin
                data_arr[pend_idx] <= merge(mem_rdata, pend_addr, pend_wdata, pend_strb);
            end else begin
                data_arr[pend_idx] <= mem_rdata;
                cpu_rdata          <= extract(mem_rdata, pend_addr, pend_size);
            end
        end
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            state      <= st_idle;
            cpu_ready  <= 1'b1;
            cpu_rvalid <= 1'b0;
            mem_req    <= 1'b0;
            mem_we     <= 1'b0;
            for (int i = 0; i < N_LINES; i++) begin
                valid_arr[i] <= 1'b0;
                dirty_arr[i] <= 1'b0;
            end
        end else begin
            cpu_rvalid <= 1'b0;
            case (state)
                st_idle: begin
                    if (accept) begin
                        if (cpu_hit) begin
                            if (cpu_wr)
                                dirty_arr[cur_idx] <= 1'b1;
                            else
                                cpu_rvalid <= 1'b1;
                        end else begin
                            cpu_ready <= 1'b0;
                            mem_req   <= 1'b1;
                            mem_we    <= victim_dirty;
                            state     <= victim_dirty ? st_writeback : st_refill;
                        end
                    end
                end
                st_writeback: begin
                    if (mem_gnt) begin
                        mem_we <= 1'b0;      // Keep req high for the refill
                        state  <= st_refill;
                    end
                end
                st_refill: begin
                    if (mem_gnt)
                        mem_req <= 1'b0;
                    if (mem_rvalid) begin
                        valid_arr[pend_idx] <= 1'b1;
                        dirty_arr[pend_idx] <= pend_wr;
                        cpu_rvalid          <= !pend_wr;
                        cpu_ready           <= 1'b1;
                        state               <= st_idle;
                    end
                end
                default: state <= st_idle;
            endcase
        end
    end

endmodule

/* logic/mem_arbiter.sv */
`timescale 1ns/1ps

module mem_arbiter import cache_pkg::*, mem_pkg::*; #(
    parameter int LINE_BYTES = 16
) (
    input  logic                    clk,
    input  logic                    rstn,

    input  logic                    req0,
    input  logic                    we0,
    input  addr_t                   addr0,
    input  logic [LINE_BYTES*8-1:0] wdata0,
    output logic                    gnt0,
    output logic                    rvalid0,
    output logic [LINE_BYTES*8-1:0] rdata0,

    input  logic                    req1,
    input  logic                    we1,
    input  addr_t                   addr1,
    input  logic [LINE_BYTES*8-1:0] wdata1,
    output logic                    gnt1,
    output logic                    rvalid1,
    output logic [LINE_BYTES*8-1:0] rdata1,

    output logic                    m_req,
    output logic                    m_we,
    output addr_t                   m_addr,
    output logic [LINE_BYTES*8-1:0] m_wdata,
    input  logic                    m_gnt,
    input  logic                    m_rvalid,
    input  logic [LINE_BYTES*8-1:0] m_rdata
);

    arb_state_t state;
    req_id_t    owner;
    req_id_t    last_served;
    req_id_t    pick;
    req_id_t    sel;

    always_comb begin
        if (req0 && req1)
            pick = ~last_served;     // Tie goes to the other one
        else if (req1)
            pick = 1'b1;
        else
            pick = 1'b0;
        sel = (state == arb_idle) ? pick : owner;
    end

    assign m_req   = (state == arb_idle) && (req0 || req1);
    assign m_we    = sel[0] ? we1    : we0;
    assign m_addr  = sel[0] ? addr1  : addr0;
    assign m_wdata = sel[0] ? wdata1 : wdata0;

    assign gnt0 = m_req && m_gnt && (pick == 1'b0);
    assign gnt1 = m_req && m_gnt && (pick == 1'b1);

    // Read data only reaches the owner
    assign rvalid0 = (state == arb_wait_data) && m_rvalid && (owner == 1'b0);
    assign rvalid1 = (state == arb_wait_data) && m_rvalid && (owner == 1'b1);
    assign rdata0  = (owner == 1'b0) ? m_rdata : '0;
    assign rdata1  = (owner == 1'b1) ? m_rdata : '0;

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            state       <= arb_idle;
            owner       <= 1'b0;
            last_served <= 1'b1;     // Port 0 wins the first tie
        end else begin
            case (state)
                arb_idle: begin
                    if (m_req && m_gnt) begin
                        owner <= pick;
                        state <= m_we ? arb_done_write : arb_wait_data;
                    end
                end
                arb_wait_data: begin
                    if (m_rvalid) begin
                        last_served <= owner;
                        state       <= arb_idle;
                    end
                end
                arb_done_write: begin
                    last_served <= owner;    // Owner raises its refill meanwhile
                    state       <= arb_idle;
                end
                default: state <= arb_idle;
            endcase
        end
    end

endmodule

/* logic/line_memory.sv */
`timescale 1ns/1ps

module line_memory import cache_pkg::*; #(
    parameter int LINE_BYTES  = 16,
    parameter int MEM_LINES   = 64,
    parameter int MEM_LATENCY = 3
) (
    input  logic                    clk,
    input  logic                    rstn,
    input  logic                    req,
    input  logic                    we,
    input  addr_t                   addr,
    input  logic [LINE_BYTES*8-1:0] wdata,
    output logic                    gnt,
    output logic                    rvalid,
    output logic [LINE_BYTES*8-1:0] rdata
);

    localparam int OFF_BITS = $clog2(LINE_BYTES);
    localparam int IDX_BITS = $clog2(MEM_LINES);
    localparam int CNT_BITS = $clog2(MEM_LATENCY + 1);

    logic [LINE_BYTES*8-1:0] mem [MEM_LINES];
    logic                    busy;
    logic [CNT_BITS-1:0]     cnt;
    logic [IDX_BITS-1:0]     rd_idx;
    logic [IDX_BITS-1:0]     idx;

    assign idx = addr[OFF_BITS +: IDX_BITS];   // Upper address bits wrap
    assign gnt = !busy;

    // Read data
    always_ff @(posedge clk) begin
        if (req && gnt && !we)
            rd_idx <= idx;
        if (busy && cnt == '0)
            rdata <= mem[rd_idx];
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            busy   <= 1'b0;
            cnt    <= '0;
            rvalid <= 1'b0;
            for (int i = 0; i < MEM_LINES; i++)
                mem[i] <= '0;
        end else begin
            rvalid <= 1'b0;
            if (busy) begin
                if (cnt == '0) begin
                    busy   <= 1'b0;
                    rvalid <= 1'b1;
                end else begin
                    cnt <= cnt - 1'b1;
                end
            end else if (req) begin
                if (we) begin
                    mem[idx] <= wdata;     // Done at grant
                end else begin
                    busy <= 1'b1;
                    cnt  <= CNT_BITS'(MEM_LATENCY - 1);
                end
            end
        end
    end

endmodule

/* logic/dual_cache_top.sv */
`timescale 1ns/1ps

module dual_cache_top import cache_pkg::*; #(
    parameter int LINE_BYTES  = 16,
    parameter int N_LINES     = 4,
    parameter int MEM_LINES   = 64,
    parameter int MEM_LATENCY = 3
) (
    input  logic  clk,
    input  logic  rstn,

    input  logic  c0_req,
    input  logic  c0_wr,
    input  addr_t c0_addr,
    input  word_t c0_wdata,
    input  strb_t c0_wstrb,
    input  size_t c0_size,
    output logic  c0_ready,
    output word_t c0_rdata,
    output logic  c0_rvalid,
    output logic  c0_hit,

    input  logic  c1_req,
    input  logic  c1_wr,
    input  addr_t c1_addr,
    input  word_t c1_wdata,
    input  strb_t c1_wstrb,
    input  size_t c1_size,
    output logic  c1_ready,
    output word_t c1_rdata,
    output logic  c1_rvalid,
    output logic  c1_hit
);

    localparam int LINE_W = LINE_BYTES * 8;

    // Cache side of the arbiter
    logic              m0_req, m0_we, m0_gnt, m0_rvalid;
    addr_t             m0_addr;
    logic [LINE_W-1:0] m0_wdata, m0_rdata;
    logic              m1_req, m1_we, m1_gnt, m1_rvalid;
    addr_t             m1_addr;
    logic [LINE_W-1:0] m1_wdata, m1_rdata;

    // Memory side
    logic              mem_req, mem_we, mem_gnt, mem_rvalid;
    addr_t             mem_addr;
    logic [LINE_W-1:0] mem_wdata, mem_rdata;

    data_cache #(
        .LINE_BYTES(LINE_BYTES),
        .N_LINES   (N_LINES)
    ) u_cache0 (
        .clk       (clk),
        .rstn      (rstn),
        .cpu_req   (c0_req),
        .cpu_wr    (c0_wr),
        .cpu_addr  (c0_addr),
        .cpu_wdata (c0_wdata),
        .cpu_wstrb (c0_wstrb),
        .cpu_size  (c0_size),
        .cpu_ready (c0_ready),
        .cpu_rdata (c0_rdata),
        .cpu_rvalid(c0_rvalid),
        .cpu_hit   (c0_hit),
        .mem_req   (m0_req),
        .mem_we    (m0_we),
        .mem_addr  (m0_addr),
        .mem_wdata (m0_wdata),
        .mem_gnt   (m0_gnt),
        .mem_rvalid(m0_rvalid),
        .mem_rdata (m0_rdata)
    );

    data_cache #(
        .LINE_BYTES(LINE_BYTES),
        .N_LINES   (N_LINES)
    ) u_cache1 (
        .clk       (clk),
        .rstn      (rstn),
        .cpu_req   (c1_req),
        .cpu_wr    (c1_wr),
        .cpu_addr  (c1_addr),
        .cpu_wdata (c1_wdata),
        .cpu_wstrb (c1_wstrb),
        .cpu_size  (c1_size),
        .cpu_ready (c1_ready),
        .cpu_rdata (c1_rdata),
        .cpu_rvalid(c1_rvalid),
        .cpu_hit   (c1_hit),
        .mem_req   (m1_req),
        .mem_we    (m1_we),
        .mem_addr  (m1_addr),
        .mem_wdata (m1_wdata),
        .mem_gnt   (m1_gnt),
        .mem_rvalid(m1_rvalid),
        .mem_rdata (m1_rdata)
    );

    mem_arbiter #(
        .LINE_BYTES(LINE_BYTES)
    ) u_arb (
        .clk     (clk),
        .rstn    (rstn),
        .req0    (m0_req),
        .we0     (m0_we),
        .addr0   (m0_addr),
        .wdata0  (m0_wdata),
        .gnt0    (m0_gnt),
        .rvalid0 (m0_rvalid),
        .rdata0  (m0_rdata),
        .req1    (m1_req),
        .we1     (m1_we),
        .addr1   (m1_addr),
        .wdata1  (m1_wdata),
        .gnt1    (m1_gnt),
        .rvalid1 (m1_rvalid),
        .rdata1  (m1_rdata),
        .m_req   (mem_req),
        .m_we    (mem_we),
        .m_addr  (mem_addr),
        .m_wdata (mem_wdata),
        .m_gnt   (mem_gnt),
        .m_rvalid(mem_rvalid),
        .m_rdata (mem_rdata)
    );

    line_memory #(
        .LINE_BYTES (LINE_BYTES),
        .MEM_LINES  (MEM_LINES),
        .MEM_LATENCY(MEM_LATENCY)
    ) u_mem (
        .clk   (clk),
        .rstn  (rstn),
        .req   (mem_req),
        .we    (mem_we),
        .addr  (mem_addr),
        .wdata (mem_wdata),
        .gnt   (mem_gnt),
        .rvalid(mem_rvalid),
        .rdata (mem_rdata)
    );

endmodule

/* tb/tb_dual_cache.sv */
`timescale 1ns/1ps

module tb_dual_cache
    import cache_pkg::*, mem_pkg::*;
();

    localparam int LINE_BYTES  = 16;
    localparam int N_LINES     = 4;
    localparam int MEM_LINES   = 64;
    localparam int MEM_LATENCY = 3;
    localparam int MEM_BYTES   = MEM_LINES * LINE_BYTES;
    localparam int CLK_PERIOD  = 8;
    localparam int N_RAND      = 150;
    localparam int PORT_OPS    = N_LINES + 4 + 2 * N_RAND;    // Worst case per port
    localparam int TIMEOUT_NS  = (2 * PORT_OPS * (2 * MEM_LATENCY + 20) + 8) * CLK_PERIOD;
    localparam logic [31:0] SEED = 32'he628eb44;

    logic  clk = 1'b0;
    logic  rstn;
    logic  c0_req, c0_wr, c0_ready, c0_rvalid, c0_hit;
    addr_t c0_addr;
    word_t c0_wdata, c0_rdata;
    strb_t c0_wstrb;
    size_t c0_size;
    logic  c1_req, c1_wr, c1_ready, c1_rvalid, c1_hit;
    addr_t c1_addr;
    word_t c1_wdata, c1_rdata;
    strb_t c1_wstrb;
    size_t c1_size;

    // Reference state
    logic [7:0]  mem_model [MEM_BYTES];
    logic        shadow_valid [2][N_LINES];
    int          shadow_tag [2][N_LINES];
    logic [31:0] rng [2];
    logic        done [2];

    dual_cache_top u_dut (.*);

    always #(CLK_PERIOD / 2) clk = ~clk;

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic logic [31:0] next_rand(input int p);
        rng[p] = xorshift(rng[p]);
        return rng[p];
    endfunction

    function automatic logic port_ready(input int p);
        return (p == 0) ? c0_ready : c1_ready;
    endfunction

    function automatic logic port_hit(input int p);
        return (p == 0) ? c0_hit : c1_hit;
    endfunction

    function automatic logic port_rvalid(input int p);
        return (p == 0) ? c0_rvalid : c1_rvalid;
    endfunction

    function automatic word_t port_rdata(input int p);
        return (p == 0) ? c0_rdata : c1_rdata;
    endfunction

    // Port p owns its half of memory
    function automatic addr_t make_addr(input int p, input int tsel, input int idx,
                                        input int off, input size_t sz);
        int o;
        o = off;
        if (sz == size_half)
            o = o & ~1;
        else if (sz != size_byte)
            o = o & ~3;
        return addr_t'(p * (MEM_BYTES / 2) + tsel * LINE_BYTES * N_LINES
                       + idx * LINE_BYTES + o);
    endfunction

    function automatic strb_t lane_mask(input addr_t a, input strb_t st, input size_t sz);
        if (st != 4'b0000)
            return st;
        case (sz)
            size_byte: return strb_t'(1 << a[1:0]);
            size_half: return a[1] ? 4'b1100 : 4'b0011;
            default:   return 4'b1111;
        endcase
    endfunction

    function automatic void model_store(input addr_t a, input word_t d, input strb_t m);
        int base;
        base = int'(a % MEM_BYTES) & ~3;
        for (int b = 0; b < 4; b++) begin
            if (m[b])
                mem_model[base + b] = d[b*8 +: 8];
        end
    endfunction

    function automatic word_t model_load(input addr_t a, input size_t sz);
        int    base;
        word_t w;
        base = int'(a % MEM_BYTES) & ~3;
        for (int b = 0; b < 4; b++)
            w[b*8 +: 8] = mem_model[base + b];
        case (sz)
            size_byte: return {24'h0, w[a[1:0]*8 +: 8]};
            size_half: return {16'h0, w[a[1]*16 +: 16]};
            default:   return w;
        endcase
    endfunction

    task automatic check(input string name, input logic [31:0] expected,
                         input logic [31:0] actual);
        if (expected !== actual) begin
            $display("MISMATCH %s expected %h actual %h", name, expected, actual);
            $display("Test failed");
            $fatal(1, "stopped at first error");
        end
    endtask

    task automatic drive(input int p, input logic req, input logic wr, input addr_t a,
                         input word_t d, input strb_t st, input size_t sz);
        if (p == 0) begin
            c0_req   <= req;
            c0_wr    <= wr;
            c0_addr  <= a;
            c0_wdata <= d;
            c0_wstrb <= st;
            c0_size  <= sz;
        end else begin
            c1_req   <= req;
            c1_wr    <= wr;
            c1_addr  <= a;
            c1_wdata <= d;
            c1_wstrb <= st;
            c1_size  <= sz;
        end
    endtask

    // One request with hit prediction, handshake and load data checks
    task automatic access(input int p, input logic wr, input addr_t a, input word_t d,
                          input strb_t st, input size_t sz, input string name);
        int    idx;
        int    tag;
        logic  exp_hit;
        word_t exp_data;
        do @(negedge clk); while (!port_ready(p));
        @(posedge clk);
        drive(p, 1'b1, wr, a, d, st, sz);
        @(negedge clk);
        idx     = int'(a / LINE_BYTES) % N_LINES;
        tag     = int'(a / (LINE_BYTES * N_LINES));
        exp_hit = shadow_valid[p][idx] && (shadow_tag[p][idx] == tag);
        check({name, " hit"}, 32'(exp_hit), 32'(port_hit(p)));
        shadow_valid[p][idx] = 1'b1;
        shadow_tag[p][idx]   = tag;
        if (wr)
            model_store(a, d, lane_mask(a, st, sz));
        else
            exp_data = model_load(a, sz);
        @(posedge clk);
        drive(p, 1'b0, wr, a, d, st, sz);
        @(negedge clk);
        // A miss holds ready low until it completes
        check({name, " ready"}, 32'(exp_hit), 32'(port_ready(p)));
        if (wr) begin
            check({name, " rvalid"}, 32'd0, 32'(port_rvalid(p)));
        end else begin
            while (!port_rvalid(p))
                @(negedge clk);
            check({name, " ready"}, 32'd1, 32'(port_ready(p)));
            check(name, exp_data, port_rdata(p));
            @(negedge clk);
            check({name, " rvalid"}, 32'd0, 32'(port_rvalid(p)));   // Single cycle pulse
        end
    endtask

    task automatic run_port(input int p);
        logic [31:0] r;
        word_t       d;
        addr_t       a;
        addr_t       first;
        size_t       sz;
        strb_t       st;
        int          idx;
        for (int i = 0; i < N_LINES; i++) begin
            r = next_rand(p);
            access(p, 1'b0, make_addr(p, 0, i, int'(r[3:0]), size_word), '0, '0,
                   size_word, "cold_load");
        end
        // Dirty line pushed out by two conflicting tags
        r     = next_rand(p);
        idx   = int'(r[1:0]) % N_LINES;
        first = make_addr(p, 0, idx, int'(r[7:4]), size_word);
        access(p, 1'b1, first, next_rand(p), '0, size_word, "eviction");
        access(p, 1'b0, make_addr(p, 1, idx, 0, size_word), '0, '0, size_word, "eviction");
        access(p, 1'b0, make_addr(p, 2, idx, 4, size_word), '0, '0, size_word, "eviction");
        access(p, 1'b0, first, '0, '0, size_word, "eviction");
        for (int n = 0; n < N_RAND; n++) begin
            r  = next_rand(p);
            d  = next_rand(p);
            sz = size_t'(r[13:12] % 3);
            st = (r[15:14] == 2'b00) ? r[19:16] : 4'b0000;
            a  = make_addr(p, int'(r[3:2] % 3), int'(r[7:4]) % N_LINES,
                           int'(r[11:8]) % LINE_BYTES, sz);
            case (r[1:0])
                2'b00:   access(p, 1'b0, a, '0, '0, sz, "size_load");
                2'b01:   access(p, 1'b1, a, d, st, sz, "store");
                default: begin
                    access(p, 1'b1, a, d, st, sz, "store_load");
                    if (r[20])
                        access(p, 1'b0, a & ~32'h3, '0, '0, size_word, "store_load_word");
                    else
                        access(p, 1'b0, a, '0, '0, sz, "store_load");
                end
            endcase
        end
    endtask

    initial begin
        rng[0] = SEED;
        rng[1] = ~SEED;
        for (int i = 0; i < MEM_BYTES; i++)
            mem_model[i] = 8'h00;
        for (int p = 0; p < 2; p++) begin
            done[p] = 1'b0;
            for (int i = 0; i < N_LINES; i++) begin
                shadow_valid[p][i] = 1'b0;
                shadow_tag[p][i]   = 0;
            end
        end
        rstn <= 1'b0;
        drive(0, 1'b0, 1'b0, '0, '0, '0, size_word);
        drive(1, 1'b0, 1'b0, '0, '0, '0, size_word);
        repeat (8) @(posedge clk);
        rstn <= 1'b1;
        fork
            begin
                run_port(0);
                done[0] = 1'b1;
            end
            begin
                run_port(1);
                done[1] = 1'b1;
            end
        join
        repeat (2) @(posedge clk);
        $display("Test passed");
        $finish;
    end

    // Watchdog
    initial begin
        arb_state_t arb_seen;
        #(TIMEOUT_NS);
        arb_seen = u_dut.u_arb.state;
        for (int p = 0; p < 2; p++) begin
            if (!done[p])
                $display("Timeout: port %0d never finished its operations, arbiter in %s",
                         p, arb_seen.name());
        end
        $display("Test failed");
        $fatal(1, "watchdog expired");
    end

endmodule

/* src.f */
logic/cache_pkg.sv
logic/mem_pkg.sv
logic/data_cache.sv
logic/mem_arbiter.sv
logic/line_memory.sv
logic/dual_cache_top.sv
tb/tb_dual_cache.sv

/* Bender.yml */
package:
  name: dual_cache

sources:
  - files:
      - logic/cache_pkg.sv
      - logic/mem_pkg.sv
      - logic/data_cache.sv
      - logic/mem_arbiter.sv
      - logic/line_memory.sv
      - logic/dual_cache_top.sv
  - target: test
    files:
      - tb/tb_dual_cache.sv
